//--- src/bsc_pkg.sv
package bsc_pkg;

   localparam int INSN_W = 32;
   localparam int REG_AW = 5;

   // RV32I major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

   // funct3 codes of the supported integer ops
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_e;

   // One instruction in flight: idle, serial execution, result held
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_EXEC,
      ST_DONE
   } state_e;

endpackage

//--- src/bsc_state.sv
`timescale 1ns/1ps

module bsc_state
   import bsc_pkg::*;
   #(parameter int WIDTH = 32)
   (
   input  logic                     clk,
   input  logic                     i_arst_n,
   // Instruction handshake
   input  logic                     i_insn_valid,
   output logic                     o_insn_ready,
   output logic                     o_accept,
   // From decode
   input  logic                     i_illegal,
   input  logic                     i_slt,
   // Bit sequencing
   output logic                     o_en,
   output logic                     o_cnt0,
   output logic                     o_cnt_done,
   output logic [$clog2(WIDTH)-1:0] o_bit_idx,
   output logic                     o_rd_wen,
   output logic                     o_fix_lsb,
   // Result handshake
   output logic                     o_res_valid,
   input  logic                     i_res_ready
   );

   localparam int CNT_W = $clog2(WIDTH);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WIDTH - 1);

   state_e           state_q;
   state_e           state_d;
   logic [CNT_W-1:0] cnt_q;

   assign o_insn_ready = (state_q == ST_IDLE);
   assign o_accept     = o_insn_ready & i_insn_valid;

   assign o_en       = (state_q == ST_EXEC);
   assign o_cnt0     = o_en & (cnt_q == '0);
   assign o_cnt_done = o_en & (cnt_q == CNT_LAST);
   assign o_bit_idx  = cnt_q;

   // Illegal words run through the sequence but never write
   assign o_rd_wen  = o_en & ~i_illegal;
   assign o_fix_lsb = o_cnt_done & i_slt;

   assign o_res_valid = (state_q == ST_DONE);

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (o_accept) begin
               state_d = ST_EXEC;
            end
         end
         ST_EXEC: begin
            if (o_cnt_done) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: begin
            if (i_res_ready) begin
               state_d = ST_IDLE;
            end
         end
         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (o_accept) begin
            cnt_q <= '0;
         end else if (o_en) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Result record may not be withdrawn before it is taken
   a_res_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_res_valid && !i_res_ready |=> o_res_valid);

endmodule

//--- src/bsc_decode.sv
`timescale 1ns/1ps

module bsc_decode
   import bsc_pkg::*;
   #(parameter int WIDTH = 32)
   (
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_accept,
   input  logic [INSN_W-1:0] i_insn,
   input  logic              i_en,
   output logic [REG_AW-1:0] o_rs1,
   output logic [REG_AW-1:0] o_rs2,
   output logic [REG_AW-1:0] o_rd,
   output alu_op_e           o_alu_op,
   output logic              o_use_imm,
   output logic              o_slt,
   output logic              o_illegal,
   output logic              o_imm_bit
   );

   // Immediate bits above WIDTH never reach the datapath
   localparam int IMM_W = (WIDTH < 12) ? WIDTH : 12;

   logic [INSN_W-1:0] insn_q;
   logic [IMM_W-1:0]  imm_sr;
   logic [6:0]        opcode;
   logic [2:0]        funct3;
   logic [6:0]        funct7;
   logic              legal;

   assign opcode = insn_q[6:0];
   assign funct3 = insn_q[14:12];
   assign funct7 = insn_q[31:25];

   assign o_rd  = insn_q[11:7];
   assign o_rs1 = insn_q[19:15];
   assign o_rs2 = insn_q[24:20];

   always_comb begin
      o_alu_op = ALU_ADD;
      legal    = 1'b0;
      if ((opcode == OPC_OP) || (opcode == OPC_OP_IMM)) begin
         legal = 1'b1;
         case (funct3)
            F3_ADD: begin
               if ((opcode == OPC_OP) && (funct7 == F7_SUB)) begin
                  o_alu_op = ALU_SUB;
               end
            end
            F3_SLT:  o_alu_op = ALU_SLT;
            F3_SLTU: o_alu_op = ALU_SLTU;
            F3_XOR:  o_alu_op = ALU_XOR;
            F3_OR:   o_alu_op = ALU_OR;
            F3_AND:  o_alu_op = ALU_AND;
            // Shifts are not implemented
            default: legal = 1'b0;
         endcase
         // Register form only knows funct7 zero, plus SUB
         if ((opcode == OPC_OP) && (funct7 != F7_BASE) &&
             !((funct3 == F3_ADD) && (funct7 == F7_SUB))) begin
            legal = 1'b0;
         end
      end
   end

   assign o_illegal = ~legal;
   assign o_use_imm = (opcode == OPC_OP_IMM);
   assign o_slt     = legal & ((o_alu_op == ALU_SLT) | (o_alu_op == ALU_SLTU));
   assign o_imm_bit = imm_sr[0];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         insn_q <= '0;
         imm_sr <= '0;
      end else if (i_accept) begin
         insn_q <= i_insn;
         imm_sr <= i_insn[20 +: IMM_W];
      end else if (i_en) begin
         // Top bit refills itself, giving the sign extension
         imm_sr <= {imm_sr[IMM_W-1], imm_sr[IMM_W-1:1]};
      end
   end

endmodule

//--- src/bsc_alu.sv
`timescale 1ns/1ps

module bsc_alu
   import bsc_pkg::*;
   #(parameter int WIDTH = 32)
   (
   input  logic    clk,
   input  logic    i_arst_n,
   input  logic    i_en,
   input  logic    i_cnt0,
   input  alu_op_e i_op,
   input  logic    i_use_imm,
   input  logic    i_rs1,
   input  logic    i_rs2,
   input  logic    i_imm_bit,
   output logic    o_rd,
   output logic    o_cmp
   );

   logic op_b;
   logic sub;
   logic b_inv;
   logic cin;
   logic sum;
   logic cout;
   logic carry_q;

   assign op_b = i_use_imm ? i_imm_bit : i_rs2;

   // Compares are done as a subtraction
   assign sub   = (i_op == ALU_SUB) | (i_op == ALU_SLT) | (i_op == ALU_SLTU);
   assign b_inv = op_b ^ sub;

   // Two's complement +1 enters as the carry into bit 0
   assign cin  = i_cnt0 ? sub : carry_q;
   assign sum  = i_rs1 ^ b_inv ^ cin;
   assign cout = (i_rs1 & b_inv) | (cin & (i_rs1 ^ b_inv));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
      end else if (i_en) begin
         carry_q <= cout;
      end
   end

   always_comb begin
      case (i_op)
         ALU_ADD, ALU_SUB: o_rd = sum;
         ALU_XOR:          o_rd = i_rs1 ^ op_b;
         ALU_OR:           o_rd = i_rs1 | op_b;
         ALU_AND:          o_rd = i_rs1 & op_b;
         default:          o_rd = 1'b0;
      endcase
   end

   // Borrow out gives unsigned less-than, differing sign bits flip it for signed
   assign o_cmp = ~cout ^ ((i_op == ALU_SLT) & (i_rs1 ^ op_b));

   // Carry preset must come exactly WIDTH bits before the operation ends
   a_cnt0_span: assert property (@(posedge clk) disable iff (!i_arst_n)
      $fell(i_en) |-> $past(i_cnt0, WIDTH));

endmodule

//--- src/bsc_rf.sv
`timescale 1ns/1ps

module bsc_rf
   import bsc_pkg::*;
   #(parameter int WIDTH = 32)
   (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic [$clog2(WIDTH)-1:0] i_bit_idx,
   input  logic [REG_AW-1:0]        i_rs1_addr,
   input  logic [REG_AW-1:0]        i_rs2_addr,
   input  logic [REG_AW-1:0]        i_rd_addr,
   input  logic                     i_wen,
   input  logic                     i_wbit,
   input  logic                     i_fix_lsb,
   input  logic                     i_cmp,
   output logic                     o_rs1,
   output logic                     o_rs2,
   output logic [WIDTH-1:0]         o_rd_word
   );

   localparam int NREG  = 2 ** REG_AW;
   localparam int IDX_W = $clog2(WIDTH);
   localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WIDTH - 1);

   logic [WIDTH-1:0] regs [NREG];

   // Same-index read and write, so the bit is consumed before it is replaced
   assign o_rs1 = regs[i_rs1_addr][i_bit_idx];
   assign o_rs2 = regs[i_rs2_addr][i_bit_idx];

   assign o_rd_word = regs[i_rd_addr];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wen && (i_rd_addr != '0)) begin
         regs[i_rd_addr][i_bit_idx] <= i_wbit;
         // Compare result lands in bit 0 on the last step
         if (i_fix_lsb) begin
            regs[i_rd_addr][0] <= i_cmp;
         end
      end
   end

   // Write burst ends with the last bit
   a_wen_range: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_wen && (i_bit_idx == LAST_IDX) |=> !i_wen);

   // Each write burst starts at bit 0
   a_wen_start: assert property (@(posedge clk) disable iff (!i_arst_n)
      $rose(i_wen) |-> (i_bit_idx == '0));

endmodule

//--- src/bsc_top.sv
`timescale 1ns/1ps

module bsc_top
   import bsc_pkg::*;
   #(parameter int WIDTH = 32)
   (
   input  logic              clk,
   input  logic              i_arst_n,
   input  logic              i_insn_valid,
   output logic              o_insn_ready,
   input  logic [INSN_W-1:0] i_insn,
   output logic              o_res_valid,
   input  logic              i_res_ready,
   output logic [REG_AW-1:0] o_res_rd,
   output logic [WIDTH-1:0]  o_res_data,
   output logic              o_res_illegal
   );

   localparam int BW = $clog2(WIDTH);

   logic              accept;
   logic              en;
   logic              cnt0;
   logic [BW-1:0]     bit_idx;
   logic              rd_wen;
   logic              fix_lsb;
   logic [REG_AW-1:0] rs1_addr;
   logic [REG_AW-1:0] rs2_addr;
   alu_op_e           alu_op;
   logic              use_imm;
   logic              slt;
   logic              imm_bit;
   logic              rs1;
   logic              rs2;
   logic              alu_rd;
   logic              cmp;

   bsc_state #(.WIDTH(WIDTH)) u_state (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_insn_valid (i_insn_valid),
      .o_insn_ready (o_insn_ready),
      .o_accept     (accept),
      .i_illegal    (o_res_illegal),
      .i_slt        (slt),
      .o_en         (en),
      .o_cnt0       (cnt0),
      .o_cnt_done   (),
      .o_bit_idx    (bit_idx),
      .o_rd_wen     (rd_wen),
      .o_fix_lsb    (fix_lsb),
      .o_res_valid  (o_res_valid),
      .i_res_ready  (i_res_ready)
   );

   bsc_decode #(.WIDTH(WIDTH)) u_decode (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_accept  (accept),
      .i_insn    (i_insn),
      .i_en      (en),
      .o_rs1     (rs1_addr),
      .o_rs2     (rs2_addr),
      .o_rd      (o_res_rd),
      .o_alu_op  (alu_op),
      .o_use_imm (use_imm),
      .o_slt     (slt),
      .o_illegal (o_res_illegal),
      .o_imm_bit (imm_bit)
   );

   bsc_alu #(.WIDTH(WIDTH)) u_alu (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_en      (en),
      .i_cnt0    (cnt0),
      .i_op      (alu_op),
      .i_use_imm (use_imm),
      .i_rs1     (rs1),
      .i_rs2     (rs2),
      .i_imm_bit (imm_bit),
      .o_rd      (alu_rd),
      .o_cmp     (cmp)
   );

   bsc_rf #(.WIDTH(WIDTH)) u_rf (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_bit_idx  (bit_idx),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (o_res_rd),
      .i_wen      (rd_wen),
      .i_wbit     (alu_rd),
      .i_fix_lsb  (fix_lsb),
      .i_cmp      (cmp),
      .o_rs1      (rs1),
      .o_rs2      (rs2),
      .o_rd_word  (o_res_data)
   );

endmodule

//--- testbench/tb_bsc_top.sv
`timescale 1ns/1ps

module tb_bsc_top
   import bsc_pkg::*;
   ();

   localparam int WIDTH      = 32;
   localparam int WAIT_LIMIT = 20 * WIDTH;

   typedef struct packed {
      logic [REG_AW-1:0] rd;
      logic [WIDTH-1:0]  data;
      logic              illegal;
   } rec_t;

   logic              clk;
   logic              i_arst_n;
   logic              i_insn_valid;
   logic              o_insn_ready;
   logic [INSN_W-1:0] i_insn;
   logic              o_res_valid;
   logic              i_res_ready;
   logic [REG_AW-1:0] o_res_rd;
   logic [WIDTH-1:0]  o_res_data;
   logic              o_res_illegal;

   integer           seed = 32'h0ed5_7bc3;
   int               cycle_cnt = 0;
   int               err_cnt = 0;
   int               fail_cnt = 0;
   int               sent_cnt = 0;
   int               results_seen = 0;
   logic             stall_en = 1'b0;
   logic [1023:0]    stall_bits;
   logic [WIDTH-1:0] model_rf [32];
   rec_t             exp_q [$];
   int               accept_q [$];

   bsc_top #(.WIDTH(WIDTH)) DUT (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_insn_valid  (i_insn_valid),
      .o_insn_ready  (o_insn_ready),
      .i_insn        (i_insn),
      .o_res_valid   (o_res_valid),
      .i_res_ready   (i_res_ready),
      .o_res_rd      (o_res_rd),
      .o_res_data    (o_res_data),
      .o_res_illegal (o_res_illegal)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Result ready follows a fixed random pattern once stalls are on
   initial begin
      i_res_ready = 1'b0;
      forever begin
         @(posedge clk);
         i_res_ready <= stall_en ? stall_bits[cycle_cnt[9:0]] : 1'b1;
      end
   end

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      fail_cnt++;
      $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
      $display("Checked %0d of %0d results: %0d value errors, %0d other errors",
               results_seen, sent_cnt, err_cnt, fail_cnt);
      $display("TB FAILED");
      $finish;
   endtask

   function automatic logic [INSN_W-1:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
      enc_r = {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [INSN_W-1:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
      enc_i = {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   // Expected record, from the RV32I rules and the model register file
   function automatic rec_t ref_exec(input logic [INSN_W-1:0] insn);
      rec_t             rec;
      logic [6:0]       opc;
      logic [2:0]       f3;
      logic [6:0]       f7;
      logic [WIDTH-1:0] a;
      logic [WIDTH-1:0] b;
      logic [WIDTH-1:0] res;
      logic             ok;
      opc = insn[6:0];
      f3  = insn[14:12];
      f7  = insn[31:25];
      a   = model_rf[insn[19:15]];
      b   = (opc == OPC_OP_IMM) ? {{(WIDTH-12){insn[31]}}, insn[31:20]}
                                : model_rf[insn[24:20]];
      res = '0;
      ok  = (opc == OPC_OP_IMM) ||
            ((opc == OPC_OP) && ((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'b000))));
      case (f3)
         3'b000:  res = ((opc == OPC_OP) && (f7 == 7'h20)) ? a - b : a + b;
         3'b010:  res[0] = $signed(a) < $signed(b);
         3'b011:  res[0] = a < b;
         3'b100:  res = a ^ b;
         3'b110:  res = a | b;
         3'b111:  res = a & b;
         default: ok = 1'b0;
      endcase
      rec.rd      = insn[11:7];
      rec.illegal = ~ok;
      rec.data    = (ok && (insn[11:7] != 5'd0)) ? res : model_rf[insn[11:7]];
      return rec;
   endfunction

   function automatic logic [INSN_W-1:0] rr_insn(input logic [31:0] r);
      case (r[17:15])
         3'd1, 3'd5: rr_insn = enc_r(F7_SUB, r[9:5], r[4:0], F3_ADD, r[14:10]);
         3'd2, 3'd6: rr_insn = enc_r(F7_BASE, r[9:5], r[4:0], F3_XOR, r[14:10]);
         3'd3:       rr_insn = enc_r(F7_BASE, r[9:5], r[4:0], F3_OR, r[14:10]);
         3'd4, 3'd7: rr_insn = enc_r(F7_BASE, r[9:5], r[4:0], F3_AND, r[14:10]);
         default:    rr_insn = enc_r(F7_BASE, r[9:5], r[4:0], F3_ADD, r[14:10]);
      endcase
   endfunction

   // Register ops, any funct3 with an immediate, compares or a raw word
   function automatic logic [INSN_W-1:0] mixed_insn(input logic [31:0] r,
                                                    input logic [31:0] s);
      case (r[31:30])
         2'd0:    mixed_insn = rr_insn(r);
         2'd1:    mixed_insn = enc_i(s[11:0], r[4:0], r[22:20], r[14:10]);
         2'd2:    mixed_insn = enc_r(F7_BASE, r[9:5], r[4:0], r[20] ? F3_SLTU : F3_SLT,
                                     r[14:10]);
         default: mixed_insn = s;
      endcase
   endfunction

   task automatic send_insn(input logic [INSN_W-1:0] insn);
      rec_t exp;
      int   waited;
      exp = ref_exec(insn);
      if (!exp.illegal && (exp.rd != 5'd0)) begin
         model_rf[exp.rd] = exp.data;
      end
      exp_q.push_back(exp);
      sent_cnt++;
      @(posedge clk);
      i_insn_valid <= 1'b1;
      i_insn       <= insn;
      waited = 0;
      @(negedge clk);
      while (!o_insn_ready) begin
         if (waited >= WAIT_LIMIT) begin
            stop_on_timeout("instruction was never accepted");
         end
         waited++;
         @(negedge clk);
      end
      // Transfer happens on the coming edge
      accept_q.push_back(cycle_cnt + 1);
      @(posedge clk);
      i_insn_valid <= 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (results_seen < sent_cnt) begin
         if (waited >= WAIT_LIMIT) begin
            stop_on_timeout("not every instruction returned a result");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   initial begin : compare
      rec_t              exp;
      logic              in_record;
      logic [REG_AW-1:0] held_rd;
      logic [WIDTH-1:0]  held_data;
      logic              held_illegal;
      in_record = 1'b0;
      forever begin
         @(negedge clk);
         if (o_res_valid) begin
            if (!in_record) begin
               in_record    = 1'b1;
               held_rd      = o_res_rd;
               held_data    = o_res_data;
               held_illegal = o_res_illegal;
               if ((accept_q.size() == 0) || (exp_q.size() == 0)) begin
                  fail_cnt++;
                  $display("Result at %0t has no accepted instruction behind it", $time);
               end else begin
                  check_val("latency", 64'(cycle_cnt - accept_q.pop_front()), 64'(WIDTH));
                  exp = exp_q.pop_front();
                  check_val("o_res_rd", 64'(o_res_rd), 64'(exp.rd));
                  check_val("o_res_data", 64'(o_res_data), 64'(exp.data));
                  check_val("o_res_illegal", 64'(o_res_illegal), 64'(exp.illegal));
               end
            end else begin
               // Held under back-pressure
               check_val("o_res_rd", 64'(o_res_rd), 64'(held_rd));
               check_val("o_res_data", 64'(o_res_data), 64'(held_data));
               check_val("o_res_illegal", 64'(o_res_illegal), 64'(held_illegal));
            end
            if (i_res_ready) begin
               in_record = 1'b0;
               results_seen++;
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [31:0] s;
      i_arst_n     = 1'b0;
      i_insn_valid = 1'b0;
      i_insn       = '0;
      for (int i = 0; i < 32; i++) begin
         model_rf[i] = '0;
      end
      for (int k = 0; k < 32; k++) begin
         stall_bits[k*32 +: 32] = $random(seed);
      end
      repeat (16) @(posedge clk);
      i_arst_n <= 1'b1;
      @(negedge clk);
      check_val("o_insn_ready", 64'(o_insn_ready), 64'd1);
      check_val("o_res_valid", 64'(o_res_valid), 64'd0);

      for (int i = 1; i < 32; i++) begin
         r = $random(seed);
         send_insn(enc_i(r[11:0], 5'd0, F3_ADD, 5'(i)));
      end
      // Doubling x7 in place until it overflows
      repeat (24) send_insn(enc_r(F7_BASE, 5'd7, 5'd7, F3_ADD, 5'd7));
      repeat (60) begin
         r = $random(seed);
         send_insn(rr_insn(r));
      end

      // Compares with known signs, equal operands, then random
      send_insn(enc_i(12'hffb, 5'd0, F3_ADD, 5'd10));
      send_insn(enc_i(12'h007, 5'd0, F3_ADD, 5'd11));
      send_insn(enc_r(F7_BASE, 5'd11, 5'd10, F3_SLT, 5'd12));
      send_insn(enc_r(F7_BASE, 5'd11, 5'd10, F3_SLTU, 5'd12));
      send_insn(enc_r(F7_BASE, 5'd10, 5'd11, F3_SLT, 5'd12));
      send_insn(enc_r(F7_BASE, 5'd10, 5'd11, F3_SLTU, 5'd12));
      send_insn(enc_r(F7_BASE, 5'd9, 5'd9, F3_SLT, 5'd8));
      send_insn(enc_r(F7_BASE, 5'd9, 5'd9, F3_SLTU, 5'd8));
      send_insn(enc_i(12'hfff, 5'd10, F3_SLT, 5'd13));
      send_insn(enc_i(12'hfff, 5'd11, F3_SLTU, 5'd13));
      repeat (20) begin
         r = $random(seed);
         s = $random(seed);
         send_insn(enc_r(F7_BASE, r[9:5], r[4:0], r[20] ? F3_SLTU : F3_SLT, r[14:10]));
         send_insn(enc_i(s[11:0], r[4:0], r[21] ? F3_SLTU : F3_SLT, r[19:15]));
      end

      // x0 as destination and source, rd equal to rs1
      send_insn(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0));
      send_insn(enc_i(12'h005, 5'd3, F3_ADD, 5'd0));
      send_insn(enc_r(F7_BASE, 5'd4, 5'd0, F3_ADD, 5'd14));
      send_insn(enc_r(F7_SUB, 5'd5, 5'd0, F3_ADD, 5'd15));
      send_insn(enc_r(F7_SUB, 5'd6, 5'd5, F3_ADD, 5'd5));
      send_insn(enc_r(F7_BASE, 5'd6, 5'd6, F3_XOR, 5'd6));
      send_insn(enc_r(F7_BASE, 5'd17, 5'd16, F3_SLT, 5'd16));

      // Illegal words: load, jump, shift, bad funct7, M extension
      send_insn(32'h0000_0000);
      send_insn(32'h0000_2083);
      send_insn(32'h0000_00ef);
      send_insn(32'h0010_9093);
      send_insn(enc_r(F7_SUB, 5'd2, 5'd1, F3_XOR, 5'd3));
      send_insn(enc_r(7'h01, 5'd2, 5'd1, F3_ADD, 5'd4));
      repeat (20) send_insn($random(seed));

      stall_en <= 1'b1;
      repeat (80) begin
         r = $random(seed);
         s = $random(seed);
         send_insn(mixed_insn(r, s));
      end

      wait_drain();
      $display("Checked %0d of %0d results: %0d value errors, %0d other errors",
               results_seen, sent_cnt, err_cnt, fail_cnt);
      if ((err_cnt == 0) && (fail_cnt == 0) && (results_seen == sent_cnt)) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- bitserial_core.f
src/bsc_pkg.sv
src/bsc_state.sv
src/bsc_decode.sv
src/bsc_alu.sv
src/bsc_rf.sv
src/bsc_top.sv
testbench/tb_bsc_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bsc_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_bsc_top \
   -f bitserial_core.f \
   -o tb_bsc_top
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_bsc_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1
